/* rtl/tap_pkg.sv */
// Shared constants and the TAP state type for the JTAG TAP controller
// Instruction codes not listed here select BYPASS
// State encoding follows the usual 1149.1 numbering
package tap_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ir_w       = 4;
    localparam int idcode_w   = 32;
    localparam int sys_ctrl_w = 1;
    localparam int dap_id_w   = 2;

    // ----------------------------------------
    // Instruction codes
    // ----------------------------------------
    localparam logic [ir_w-1:0] instr_idcode   = 4'h1;
    localparam logic [ir_w-1:0] instr_bypass   = 4'hF;
    localparam logic [ir_w-1:0] instr_sys_ctrl = 4'h9;
    localparam logic [ir_w-1:0] instr_dbg_id   = 4'h3;
    localparam logic [ir_w-1:0] instr_dap_ctrl = 4'h4;
    localparam logic [ir_w-1:0] instr_dap_cmd  = 4'h6;

    // Capture values
    localparam logic [idcode_w-1:0] idcode_value     = 32'h1A2B_C3D5; // LSB set per JTAG
    localparam logic [ir_w-1:0]     ir_capture_value = 4'b0001;

    // DAP chain identifiers
    localparam logic [dap_id_w-1:0] dap_id_dbg_id   = 2'd0;
    localparam logic [dap_id_w-1:0] dap_id_dap_ctrl = 2'd1;
    localparam logic [dap_id_w-1:0] dap_id_dap_cmd  = 2'd2;

    // ----------------------------------------
    // TAP states
    // ----------------------------------------
    typedef enum logic [3:0] {
        st_reset      = 4'hF, // Test-Logic-Reset
        st_idle       = 4'hC, // Run-Test/Idle
        st_dr_select  = 4'h7,
        st_dr_capture = 4'h6,
        st_dr_shift   = 4'h2,
        st_dr_exit1   = 4'h1,
        st_dr_pause   = 4'h3,
        st_dr_exit2   = 4'h0,
        st_dr_update  = 4'h5,
        st_ir_select  = 4'h4,
        st_ir_capture = 4'hE,
        st_ir_shift   = 4'hA,
        st_ir_exit1   = 4'h9,
        st_ir_pause   = 4'hB,
        st_ir_exit2   = 4'h8,
        st_ir_update  = 4'hD
    } tap_state_e;

endpackage

/* rtl/tap_ifs.sv */
// Internal interfaces of the TAP controller
// tap_ctrl_if is driven only by the FSM, dr_sel_if only by the IR block

// FSM state and registered strobes
interface tap_ctrl_if import tap_pkg::*; ();
    tap_state_e state;
    logic       rst_sync;   // Low while in Test-Logic-Reset
    logic       ir_shift;
    logic       dr_capture;
    logic       dr_shift;
    logic       dr_update;

    modport fsm (
        output state, rst_sync, ir_shift, dr_capture, dr_shift, dr_update
    );

    modport ctrl_user (
        input state, rst_sync, ir_shift, dr_capture, dr_shift, dr_update
    );
endinterface

// Decoded data register selection, one-hot over the four sel lines
interface dr_sel_if import tap_pkg::*; ();
    logic                sel_bypass;
    logic                sel_idcode;
    logic                sel_sys_ctrl;
    logic                sel_dap;
    logic [dap_id_w-1:0] dap_id;
    logic                ir_tdo;      // IR shift register LSB

    modport ir_src (
        output sel_bypass, sel_idcode, sel_sys_ctrl, sel_dap, dap_id, ir_tdo
    );

    modport dr_sink (
        input sel_bypass, sel_idcode, sel_sys_ctrl, sel_dap, ir_tdo
    );
endinterface

/* rtl/tap_fsm.sv */
// Sixteen-state TAP controller FSM
// Strobes are registered from state and tms, so no combinational tms path
// rst_sync is a falling-edge flop, low while in Test-Logic-Reset
module tap_fsm
    import tap_pkg::*;
(
    input  logic    tck,
    input  logic    trst_n,
    input  logic    tms,
    tap_ctrl_if.fsm ctrl
);

    tap_state_e state_q;
    tap_state_e state_next;
    logic       rst_sync_q;
    logic       ir_shift_q;
    logic       dr_capture_q;
    logic       dr_shift_q;
    logic       dr_update_q;

    // ----------------------------------------
    // State register and next-state table
    // ----------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            state_q <= st_reset;
        end else begin
            state_q <= state_next;
        end
    end

    always_comb begin
        case (state_q)
            st_reset:      state_next = tms ? st_reset     : st_idle;
            st_idle:       state_next = tms ? st_dr_select : st_idle;
            st_dr_select:  state_next = tms ? st_ir_select : st_dr_capture;
            st_dr_capture: state_next = tms ? st_dr_exit1  : st_dr_shift;
            st_dr_shift:   state_next = tms ? st_dr_exit1  : st_dr_shift;
            st_dr_exit1:   state_next = tms ? st_dr_update : st_dr_pause;
            st_dr_pause:   state_next = tms ? st_dr_exit2  : st_dr_pause;
            st_dr_exit2:   state_next = tms ? st_dr_update : st_dr_shift;
            st_dr_update:  state_next = tms ? st_dr_select : st_idle;
            st_ir_select:  state_next = tms ? st_reset     : st_ir_capture;
            st_ir_capture: state_next = tms ? st_ir_exit1  : st_ir_shift;
            st_ir_shift:   state_next = tms ? st_ir_exit1  : st_ir_shift;
            st_ir_exit1:   state_next = tms ? st_ir_update : st_ir_pause;
            st_ir_pause:   state_next = tms ? st_ir_exit2  : st_ir_pause;
            st_ir_exit2:   state_next = tms ? st_ir_update : st_ir_shift;
            st_ir_update:  state_next = tms ? st_dr_select : st_idle;
            default:       state_next = st_reset;
        endcase
    end

    // ----------------------------------------
    // Internal synchronous reset
    // ----------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            rst_sync_q <= 1'b0;
        end else begin
            rst_sync_q <= (state_q != st_reset);
        end
    end

    // ----------------------------------------
    // Strobes, high for the cycle in the matching state
    // ----------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_shift_q   <= 1'b0;
            dr_capture_q <= 1'b0;
            dr_shift_q   <= 1'b0;
            dr_update_q  <= 1'b0;
        end else if (!rst_sync_q) begin
            ir_shift_q   <= 1'b0;
            dr_capture_q <= 1'b0;
            dr_shift_q   <= 1'b0;
            dr_update_q  <= 1'b0;
        end else begin
            ir_shift_q   <= (state_next == st_ir_shift);
            dr_capture_q <= (state_next == st_dr_capture);
            dr_shift_q   <= (state_next == st_dr_shift);
            dr_update_q  <= (state_next == st_dr_update);
        end
    end

    assign ctrl.state      = state_q;
    assign ctrl.rst_sync   = rst_sync_q;
    assign ctrl.ir_shift   = ir_shift_q;
    assign ctrl.dr_capture = dr_capture_q;
    assign ctrl.dr_shift   = dr_shift_q;
    assign ctrl.dr_update  = dr_update_q;

endmodule

/* rtl/tap_ir.sv */
// Instruction register with shift and hold stages, plus the DR decoder
// Hold stage updates on the falling edge in Update-IR
// Unknown instruction codes select BYPASS
module tap_ir
    import tap_pkg::*;
(
    input  logic          tck,
    input  logic          trst_n,
    input  logic          tdi,
    tap_ctrl_if.ctrl_user ctrl,
    dr_sel_if.ir_src      sel
);

    logic [ir_w-1:0] ir_sr;     // Shift stage
    logic [ir_w-1:0] ir_hold;   // Active instruction

    // ----------------------------------------
    // Shift stage
    // ----------------------------------------
    // Always passes Capture-IR before it can reach Update-IR
    always_ff @(posedge tck) begin
        if (ctrl.state == st_ir_capture) begin
            ir_sr <= ir_capture_value;
        end else if (ctrl.ir_shift) begin
            ir_sr <= {tdi, ir_sr[ir_w-1:1]};   // LSB out first
        end
    end

    // ----------------------------------------
    // Hold stage
    // ----------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_hold <= instr_idcode;
        end else if (!ctrl.rst_sync) begin
            ir_hold <= instr_idcode;
        end else if (ctrl.state == st_ir_update) begin
            ir_hold <= ir_sr;
        end
    end

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    always_comb begin
        sel.sel_bypass   = 1'b0;
        sel.sel_idcode   = 1'b0;
        sel.sel_sys_ctrl = 1'b0;
        sel.sel_dap      = 1'b0;
        sel.dap_id       = '0;
        case (ir_hold)
            instr_idcode:   sel.sel_idcode   = 1'b1;
            instr_sys_ctrl: sel.sel_sys_ctrl = 1'b1;
            instr_dbg_id: begin
                sel.sel_dap = 1'b1;
                sel.dap_id  = dap_id_dbg_id;
            end
            instr_dap_ctrl: begin
                sel.sel_dap = 1'b1;
                sel.dap_id  = dap_id_dap_ctrl;
            end
            instr_dap_cmd: begin
                sel.sel_dap = 1'b1;
                sel.dap_id  = dap_id_dap_cmd;
            end
            default:        sel.sel_bypass   = 1'b1;  // instr_bypass and undefined codes
        endcase
    end

    assign sel.ir_tdo = ir_sr[0];

endmodule

/* rtl/tap_data_path.sv */
// Local data registers, DR output mux and the falling-edge TDO stage
// Registers capture, shift and update at the edge that ends the state
// The DAP chain itself lives outside; only its serial output is muxed here
module tap_data_path
    import tap_pkg::*;
(
    input  logic          tck,
    input  logic          trst_n,
    input  logic          tdi,
    tap_ctrl_if.ctrl_user ctrl,
    dr_sel_if.dr_sink     sel,
    input  logic          sys_rst_sts,
    output logic          sys_rst_ctrl,
    input  logic          dap_ch_tdo,
    output logic          tdo,
    output logic          tdo_en
);

    logic                  bypass_q;
    logic [idcode_w-1:0]   idcode_sr;
    logic [sys_ctrl_w-1:0] sys_ctrl_sr;   // Shift stage
    logic [sys_ctrl_w-1:0] sys_ctrl_q;    // Update latch
    logic                  dr_out;
    logic                  tdo_next;
    logic                  tdo_en_next;
    logic                  tdo_q;
    logic                  tdo_en_q;

    // ----------------------------------------
    // BYPASS
    // ----------------------------------------
    always_ff @(posedge tck) begin
        if (sel.sel_bypass) begin
            if (ctrl.dr_capture) begin
                bypass_q <= 1'b0;
            end else if (ctrl.dr_shift) begin
                bypass_q <= tdi;
            end
        end
    end

    // ----------------------------------------
    // IDCODE
    // ----------------------------------------
    always_ff @(posedge tck) begin
        if (sel.sel_idcode) begin
            if (ctrl.dr_capture) begin
                idcode_sr <= idcode_value;
            end else if (ctrl.dr_shift) begin
                idcode_sr <= {tdi, idcode_sr[idcode_w-1:1]};
            end
        end
    end

    // ----------------------------------------
    // SYS_CTRL
    // ----------------------------------------
    always_ff @(posedge tck) begin
        if (sel.sel_sys_ctrl) begin
            if (ctrl.dr_capture) begin
                sys_ctrl_sr <= sys_ctrl_w'(sys_rst_sts);   // Reset status in bit 0
            end else if (ctrl.dr_shift) begin
                sys_ctrl_sr <= sys_ctrl_w'({tdi, sys_ctrl_sr} >> 1);
            end
        end
    end

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            sys_ctrl_q <= '0;
        end else if (!ctrl.rst_sync) begin
            sys_ctrl_q <= '0;
        end else if (sel.sel_sys_ctrl && ctrl.dr_update) begin
            sys_ctrl_q <= sys_ctrl_sr;
        end
    end

    assign sys_rst_ctrl = sys_ctrl_q[0];

    // ----------------------------------------
    // Output mux and TDO stage
    // ----------------------------------------
    always_comb begin
        if (sel.sel_dap) begin
            dr_out = dap_ch_tdo;
        end else if (sel.sel_sys_ctrl) begin
            dr_out = sys_ctrl_sr[0];
        end else if (sel.sel_idcode) begin
            dr_out = idcode_sr[0];
        end else begin
            dr_out = bypass_q;
        end
    end

    always_comb begin
        tdo_next    = 1'b0;
        tdo_en_next = 1'b0;
        if (ctrl.dr_shift) begin
            tdo_next    = dr_out;
            tdo_en_next = 1'b1;
        end else if (ctrl.ir_shift) begin
            tdo_next    = sel.ir_tdo;
            tdo_en_next = 1'b1;
        end
    end

    // Half a cycle of hold time for the master's rising-edge sample
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else if (!ctrl.rst_sync) begin
            tdo_q    <= 1'b0;
            tdo_en_q <= 1'b0;
        end else begin
            tdo_q    <= tdo_next;
            tdo_en_q <= tdo_en_next;
        end
    end

    assign tdo    = tdo_q;
    assign tdo_en = tdo_en_q;

endmodule

/* rtl/tap_ctrl_top.sv */
// JTAG TAP controller top level with plain JTAG, system and DAP ports
// DAP strobes are the DR strobes of the FSM, dap_ch_tdi is tdi
// dap_ch_tdo is sampled only while a DAP chain is selected
module tap_ctrl_top
    import tap_pkg::*;
(
    // JTAG
    input  logic                trst_n,
    input  logic                tck,
    input  logic                tms,
    input  logic                tdi,
    output logic                tdo,
    output logic                tdo_en,
    // System control and status
    output logic                sys_rst_ctrl,
    input  logic                sys_rst_sts,
    // DAP scan chains
    output logic                dap_ch_sel,
    output logic [dap_id_w-1:0] dap_ch_id,
    output logic                dap_ch_capture,
    output logic                dap_ch_shift,
    output logic                dap_ch_update,
    output logic                dap_ch_tdi,
    input  logic                dap_ch_tdo
);

    tap_ctrl_if u_ctrl_if ();
    dr_sel_if   u_sel_if ();

    tap_fsm u_tap_fsm (
        .tck    (tck),
        .trst_n (trst_n),
        .tms    (tms),
        .ctrl   (u_ctrl_if)
    );

    tap_ir u_tap_ir (
        .tck    (tck),
        .trst_n (trst_n),
        .tdi    (tdi),
        .ctrl   (u_ctrl_if),
        .sel    (u_sel_if)
    );

    tap_data_path u_tap_data_path (
        .tck          (tck),
        .trst_n       (trst_n),
        .tdi          (tdi),
        .ctrl         (u_ctrl_if),
        .sel          (u_sel_if),
        .sys_rst_sts  (sys_rst_sts),
        .sys_rst_ctrl (sys_rst_ctrl),
        .dap_ch_tdo   (dap_ch_tdo),
        .tdo          (tdo),
        .tdo_en       (tdo_en)
    );

    // DAP chain forwarding
    assign dap_ch_sel     = u_sel_if.sel_dap;
    assign dap_ch_id      = u_sel_if.dap_id;
    assign dap_ch_capture = u_ctrl_if.dr_capture;
    assign dap_ch_shift   = u_ctrl_if.dr_shift;
    assign dap_ch_update  = u_ctrl_if.dr_update;
    assign dap_ch_tdi     = tdi;

endmodule

/* verif/tb_clk_gen.sv */
// Testbench clock and power-on reset
// trst_n rises on the falling edge that ends the reset window
module tb_clk_gen #(
    parameter int period     = 8,
    parameter int rst_cycles = 8
) (
    output logic tck,
    output logic trst_n
);

    int rst_count = 0;

    initial begin
        tck = 1'b1;   // First edge is a falling one
        forever #(period / 2) tck = ~tck;
    end

    always @(negedge tck) begin
        if (rst_count < rst_cycles) begin
            rst_count <= rst_count + 1;
        end
    end

    assign trst_n = (rst_count >= rst_cycles);

endmodule

/* verif/tap_tb_tasks.svh */
// JTAG driving tasks, value check, xorshift and bounded waits for tap_tb
// Included inside tap_tb and uses its signals and counters
// Inputs change on the falling edge and tdo is sampled at the rising edge
`ifndef tap_tb_tasks_svh
`define tap_tb_tasks_svh

function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic check_val(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
endtask

// Signals that a bounded wait can watch
function automatic logic probe_signal(input string name);
    if (name == "trst_n") begin
        return trst_n;
    end
    return 1'bx;
endfunction

task automatic wait_cycles_until(input string name, input logic value, input int limit);
    int n;
    n = 0;
    while (probe_signal(name) !== value && n < limit) begin
        @(negedge tck);
        n++;
    end
    if (probe_signal(name) !== value) begin
        timeouts++;
        $display("Timeout: %s did not reach %0d within %0d cycles", name, value, limit);
    end
endtask

// ----------------------------------------
// JTAG sequences
// ----------------------------------------
// One tck cycle with tdo_en expected high only while shifting
task automatic clock_tap(input logic tms_v, input logic tdi_v, input logic shifting,
                         output logic tdo_s);
    @(negedge tck);
    capture_pulses += int'(dap_ch_capture);   // Strobes are stable mid-cycle
    shift_pulses   += int'(dap_ch_shift);
    update_pulses  += int'(dap_ch_update);
    tms = tms_v;
    tdi = tdi_v;
    @(posedge tck);
    tdo_s = tdo;
    check_val("tdo_en", 32'(tdo_en), 32'(shifting));
    if (!shifting) begin
        check_val("tdo", 32'(tdo), 32'h0);
    end
    check_val("dap_ch_tdi", 32'(dap_ch_tdi), 32'(tdi_v));
endtask

task automatic goto_reset();
    logic b;
    repeat (5) begin
        clock_tap(1'b1, 1'b0, 1'b0, b);
    end
endtask

// Starts from Run-Test/Idle or Test-Logic-Reset and ends in Run-Test/Idle
task automatic load_ir(input logic [ir_w-1:0] instr, output logic [ir_w-1:0] captured);
    logic b;
    captured = '0;
    clock_tap(1'b0, 1'b0, 1'b0, b);   // Run-Test/Idle
    clock_tap(1'b1, 1'b0, 1'b0, b);   // Select-DR
    clock_tap(1'b1, 1'b0, 1'b0, b);   // Select-IR
    clock_tap(1'b0, 1'b0, 1'b0, b);   // Capture-IR
    clock_tap(1'b0, 1'b0, 1'b0, b);   // Shift-IR
    for (int i = 0; i < ir_w; i++) begin
        clock_tap(i == ir_w - 1, instr[0], 1'b1, b);
        instr    = instr >> 1;
        captured = {b, captured[ir_w-1:1]};
    end
    clock_tap(1'b1, 1'b0, 1'b0, b);   // Update-IR
    clock_tap(1'b0, 1'b0, 1'b0, b);
endtask

// Shifts n bits of din in LSB first and returns the n bits out in dout
task automatic scan_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
    logic b;
    dout = '0;
    clock_tap(1'b0, 1'b0, 1'b0, b);
    clock_tap(1'b1, 1'b0, 1'b0, b);   // Select-DR
    clock_tap(1'b0, 1'b0, 1'b0, b);   // Capture-DR
    clock_tap(1'b0, 1'b0, 1'b0, b);   // Shift-DR
    for (int i = 0; i < n; i++) begin
        clock_tap(i == n - 1, din[0], 1'b1, b);
        din  = din >> 1;
        dout = {b, dout[31:1]};
    end
    dout = dout >> (32 - n);
    clock_tap(1'b1, 1'b0, 1'b0, b);   // Update-DR
    clock_tap(1'b0, 1'b0, 1'b0, b);
endtask

`endif

/* verif/tap_tb.sv */
// Directed testbench for the JTAG TAP controller
// A stub stands in for the DAP and returns one chosen bit on dap_ch_tdo
module tap_tb
    import tap_pkg::*;
();

    localparam logic [31:0] rng_seed   = 32'h6142;
    localparam int          wait_limit = 32;

    logic                tck;
    logic                trst_n;
    logic                tms;
    logic                tdi;
    logic                tdo;
    logic                tdo_en;
    logic                sys_rst_ctrl;
    logic                sys_rst_sts;
    logic                dap_ch_sel;
    logic [dap_id_w-1:0] dap_ch_id;
    logic                dap_ch_capture;
    logic                dap_ch_shift;
    logic                dap_ch_update;
    logic                dap_ch_tdi;
    logic                dap_ch_tdo = 1'b0;
    logic                dap_tdo_val;
    logic [31:0]         rng_state;
    int                  checks;
    int                  errors;
    int                  timeouts;
    int                  capture_pulses;
    int                  shift_pulses;
    int                  update_pulses;

    tb_clk_gen #(.period(8), .rst_cycles(8)) u_clk_gen (.tck(tck), .trst_n(trst_n));

    tap_ctrl_top u_tap_ctrl_top (
        .trst_n         (trst_n),
        .tck            (tck),
        .tms            (tms),
        .tdi            (tdi),
        .tdo            (tdo),
        .tdo_en         (tdo_en),
        .sys_rst_ctrl   (sys_rst_ctrl),
        .sys_rst_sts    (sys_rst_sts),
        .dap_ch_sel     (dap_ch_sel),
        .dap_ch_id      (dap_ch_id),
        .dap_ch_capture (dap_ch_capture),
        .dap_ch_shift   (dap_ch_shift),
        .dap_ch_update  (dap_ch_update),
        .dap_ch_tdi     (dap_ch_tdi),
        .dap_ch_tdo     (dap_ch_tdo)
    );

    // DAP stub output moves only outside Shift-DR
    always @(negedge tck) begin
        if (!dap_ch_shift) begin
            dap_ch_tdo <= dap_tdo_val;
        end
    end

    `include "tap_tb_tasks.svh"

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_defaults();
        logic [31:0] dout;
        wait_cycles_until("trst_n", 1'b1, wait_limit);
        @(posedge tck);
        check_val("tdo_en", 32'(tdo_en), 32'h0);
        check_val("tdo", 32'(tdo), 32'h0);
        check_val("sys_rst_ctrl", 32'(sys_rst_ctrl), 32'h0);
        scan_dr(32, xorshift(), dout);   // IR still holds IDCODE
        check_val("idcode", dout, idcode_value);
    endtask

    task automatic bypass_delay(input logic [ir_w-1:0] instr);
        logic [ir_w-1:0] cap;
        logic [31:0]     din;
        logic [31:0]     dout;
        load_ir(instr, cap);
        check_val("ir_capture", 32'(cap), 32'(ir_capture_value));
        din = xorshift() & 32'h0000_FFFF;
        scan_dr(16, din, dout);
        check_val("bypass_out", dout, {16'h0, din[14:0], 1'b0});   // One bit late
    endtask

    task automatic sys_ctrl_loop();
        logic [ir_w-1:0] cap;
        logic [31:0]     r;
        logic [31:0]     dout;
        logic            sts;
        r = xorshift();
        for (int k = 0; k < 2; k++) begin
            sts = r[0] ^ k[0];   // Random bit first, then its complement
            @(negedge tck);
            sys_rst_sts = sts;
            load_ir(instr_sys_ctrl, cap);
            check_val("ir_capture", 32'(cap), 32'(ir_capture_value));
            scan_dr(1, 32'(k), dout);
            check_val("sys_ctrl_out", dout, 32'(sts));
            @(negedge tck);   // Update landed on the edge leaving Update-DR
            check_val("sys_rst_ctrl", 32'(sys_rst_ctrl), 32'(k));
        end
    endtask

    task automatic dap_chain_scan(input logic [ir_w-1:0] instr,
                                  input logic [dap_id_w-1:0] id, input logic val);
        logic [ir_w-1:0] cap;
        logic [31:0]     dout;
        dap_tdo_val = val;
        load_ir(instr, cap);
        check_val("ir_capture", 32'(cap), 32'(ir_capture_value));
        check_val("dap_ch_sel", 32'(dap_ch_sel), 32'h1);
        check_val("dap_ch_id", 32'(dap_ch_id), 32'(id));
        capture_pulses = 0;
        shift_pulses   = 0;
        update_pulses  = 0;
        scan_dr(8, xorshift(), dout);
        check_val("dap_ch_tdo_out", dout, val ? 32'h0000_00FF : 32'h0);
        check_val("dap_ch_capture", capture_pulses, 32'd1);
        check_val("dap_ch_shift", shift_pulses, 32'd8);
        check_val("dap_ch_update", update_pulses, 32'd1);
    endtask

    task automatic dap_deselect();
        logic [ir_w-1:0] cap;
        load_ir(instr_idcode, cap);
        check_val("dap_ch_sel", 32'(dap_ch_sel), 32'h0);
    endtask

    task automatic tlr_return();
        logic [ir_w-1:0] cap;
        logic [31:0]     dout;
        load_ir(instr_sys_ctrl, cap);
        scan_dr(1, 32'h1, dout);
        @(negedge tck);
        check_val("sys_rst_ctrl", 32'(sys_rst_ctrl), 32'h1);
        goto_reset();
        check_val("sys_rst_ctrl", 32'(sys_rst_ctrl), 32'h0);
        scan_dr(32, xorshift(), dout);   // TLR alone restores IDCODE without trst_n
        check_val("idcode", dout, idcode_value);
    endtask

    initial begin
        rng_state   = rng_seed;
        tms         = 1'b1;
        tdi         = 1'b0;
        sys_rst_sts = 1'b0;
        dap_tdo_val = 1'b0;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;

        reset_defaults();
        bypass_delay(instr_bypass);
        bypass_delay(4'hA);   // Undefined code
        sys_ctrl_loop();
        dap_chain_scan(instr_dbg_id, dap_id_dbg_id, 1'b1);
        dap_chain_scan(instr_dap_ctrl, dap_id_dap_ctrl, 1'b0);
        dap_chain_scan(instr_dap_cmd, dap_id_dap_cmd, 1'b1);
        dap_deselect();
        tlr_return();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verif
rtl/tap_pkg.sv
rtl/tap_ifs.sv
rtl/tap_fsm.sv
rtl/tap_ir.sv
rtl/tap_data_path.sv
rtl/tap_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tap_tb.sv

/* Makefile */
# Verilator build and run of the JTAG TAP controller testbench
# Any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= tap_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "test: no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
